// File: verilog.f
design/game_screen_pkg.sv
design/game_sprite_pkg.sv
design/display_timing.sv
design/sprite_mover.sv
design/game_sprite_display.sv
design/pixel_mixer.sv
design/game_top.sv
sim/game_top_props.sv
sim/game_top_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = game_top_tb
FILELIST  = verilog.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "Regression failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: sim/game_top_tb.sv
`timescale 1ns/10ps

module game_top_tb;

    localparam int h_total  = 80;
    localparam int v_total  = 56;
    localparam int n_frames = 48;          // Frames checked after reset.
    localparam int period   = 100;

    logic                  clk;
    logic                  reset;
    logic                  launch;
    logic                  hsync;
    logic                  vsync;
    logic                  video_on;
    logic                  collision;
    game_sprite_pkg::rgb_t video_rgb;

    int         launch_cycle;
    int         cycle;
    int         frames;
    int         checks;
    int         errors;
    int         frame_errors;
    int         collisions;
    bit         reset_seen = 1'b1;
    int         px;
    int         py;
    int         st[2];                     // 0 idle, 1 run, 2 frozen.
    int         pos_x[2];
    int         pos_y[2];
    bit         back_x[2];
    bit         back_y[2];
    int         step_x[2];
    int         step_y[2];
    logic [6:0] hist_old;                  // Expected outputs, two cycles old.
    logic [6:0] hist_new;

    game_top dut_i (.clk(clk), .reset(reset), .launch(launch), .hsync(hsync),
                    .vsync(vsync), .video_on(video_on), .video_rgb(video_rgb),
                    .collision(collision));

    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;

    always @(posedge clk)
        reset_seen <= reset;

    // Packs {vsync, hsync, video_on, collision, rgb} for one raster position.
    function automatic logic [6:0] expected_output(int x, int y, int s0x, int s0y,
                                                   int s1x, int s1y);
        logic                  on;
        logic                  hs;
        logic                  vs;
        logic                  hit0;
        logic                  hit1;
        int                    dx0;
        int                    dy0;
        game_sprite_pkg::rgb_t colour;
        dx0    = x - s0x;
        dy0    = y - s0y;
        on     = x < 64 && y < 48;
        hs     = x >= 68 && x <= 75;
        vs     = y == 50 || y == 51;
        hit0   = dx0 >= 0 && dx0 < 8 && dy0 >= 0 && dy0 < 8 &&
                 (dx0 == 3 || dx0 == 4 || dy0 == 3 || dy0 == 4);  // Cross.
        hit1   = x >= s1x && x < s1x + 8 && y >= s1y && y < s1y + 8;
        colour = !on ? 3'b000 : hit0 ? 3'b100 : hit1 ? 3'b010 : 3'b001;
        return {vs, hs, on, hit0 && hit1 && on, colour};
    endfunction

    task automatic step_axis(inout int pos, inout bit back, input int step, input int limit);
        if (!back)
        begin
            if (pos + 7 + step > limit)
            begin
                back = 1'b1;
                pos  = pos - step;
            end
            else
                pos = pos + step;
        end
        else if (pos - step < 0)
        begin
            back = 1'b0;
            pos  = pos + step;
        end
        else
            pos = pos - step;
    endtask

    task automatic update_mover(int i, bit coll, bit fs, bit go);
        if (st[i] == 1)
        begin
            if (coll)
                st[i] = 2;
            else if (fs)
            begin
                step_axis(pos_x[i], back_x[i], step_x[i], 63);
                step_axis(pos_y[i], back_y[i], step_y[i], 47);
            end
        end
        else if (st[i] == 0 && go && pos_x[i] + 7 <= 63 && pos_y[i] + 7 <= 47)
            st[i] = 1;
    endtask

    task automatic check_rgb(string name, game_sprite_pkg::rgb_t exp,
                             game_sprite_pkg::rgb_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            frame_errors++;
            $display("FAILED %s frame %0d: expected %b, actual %b", name, frames, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            frame_errors++;
            $display("FAILED %s frame %0d: expected %b, actual %b", name, frames, exp, act);
        end
    endtask

    initial
    begin
        reset  = 1'b1;
        launch = 1'b0;
        void'($urandom(88159));
        launch_cycle = (1 + $urandom % 3) * h_total * v_total + 10 * h_total + 5;
        {cycle, frames, checks, errors, frame_errors, collisions} = '0;
        {px, py} = '0;
        hist_old = '0;
        hist_new = '0;
        st     = '{0, 0};
        pos_x  = '{4, 48};
        pos_y  = '{4, 30};
        back_x = '{1'b0, 1'b0};
        back_y = '{1'b0, 1'b0};
        step_x = '{3, 2};
        step_y = '{2, 3};
        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (launch_cycle + 1) @(negedge clk);
        launch = 1'b1;                     // One-cycle launch strobe.
        @(negedge clk);
        launch = 1'b0;
    end

    always @(negedge clk)
        if (!reset_seen)
        begin : compare_cycle
            logic [6:0] cur;
            bit         coll;
            coll = hist_old[3];
            check_rgb("video_rgb", hist_old[2:0], video_rgb);
            check_bit("video_on", hist_old[4], video_on);
            check_bit("collision", hist_old[3], collision);
            check_bit("hsync", hist_old[5], hsync);
            check_bit("vsync", hist_old[6], vsync);
            if (coll)
                collisions++;
            cur      = expected_output(px, py, pos_x[0], pos_y[0], pos_x[1], pos_y[1]);
            hist_old = hist_new;
            hist_new = cur;
            update_mover(0, coll, px == 0 && py == 48, cycle == launch_cycle);
            update_mover(1, coll, px == 0 && py == 48, cycle == launch_cycle);
            cycle++;
            px = px + 1;
            if (px == h_total)
            begin
                px = 0;
                py = (py == v_total - 1) ? 0 : py + 1;
            end
            // A wrap back to the first pixel closes the frame.
            if (px == 0 && py == 0)
            begin
                $display("frame %0d: %0d mismatches", frames, frame_errors);
                frames++;
                frame_errors = 0;
                if (frames == n_frames)
                begin
                    if (collisions == 0)
                    begin
                        errors++;
                        $display("No collision happened in %0d frames", n_frames);
                    end
                    $display("frames %0d, checks %0d, errors %0d, collision pixels %0d",
                             frames, checks, errors, collisions);
                    if (errors == 0)
                        $display("Regression passed");
                    else
                        $display("Regression failed");
                    $finish;
                end
            end
        end

    initial
    begin
        #((n_frames + 4) * h_total * v_total * period);
        $display("Timeout: the raster did not finish %0d frames in time", n_frames);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: sim/game_top_props.sv
`timescale 1ns/10ps

module game_top_props
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  video_on,
    input  logic                  hsync,
    input  logic                  collision,
    input  game_sprite_pkg::rgb_t video_rgb
);

    // A collision can only come from a visible pixel.
    collision_visible: assert property (@(posedge clk) disable iff (reset)
        collision |-> video_on)
        else $error("collision raised outside active video");

    // Horizontal sync sits in the blanking interval.
    hsync_blank: assert property (@(posedge clk) disable iff (reset)
        hsync |-> !video_on)
        else $error("hsync high during active video");

    // Blanking is black.
    blank_black: assert property (@(posedge clk) disable iff (reset)
        !video_on |-> video_rgb == '0)
        else $error("video_rgb not black during blanking");

endmodule

bind game_top game_top_props props_i
(
    .clk(clk),
    .reset(reset),
    .video_on(video_on),
    .hsync(hsync),
    .collision(collision),
    .video_rgb(video_rgb)
);

// File: design/game_top.sv
`timescale 1ns/10ps

module game_top
#(
    parameter int                    screen_width  = 64,
    parameter int                    screen_height = 48,
    parameter int                    h_total       = 80,
    parameter int                    v_total       = 56,
    parameter int                    sprite_width  = 8,
    parameter int                    sprite_height = 8,
    parameter game_sprite_pkg::rgb_t background    = 3'b001
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  launch,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  video_on,
    output game_sprite_pkg::rgb_t video_rgb,
    output logic                  collision
);

    localparam logic [31:0] cross_bar  = 32'h000cc000;  // Red cross, clear corners.
    localparam logic [31:0] cross_line = 32'hcccccccc;
    localparam logic [31:0] square     = 32'haaaaaaaa;  // Solid green.

    game_screen_pkg::x_t   pixel_x, sprite_0_x, sprite_1_x, right_0, right_1;
    game_screen_pkg::y_t   pixel_y, sprite_0_y, sprite_1_y, bottom_0, bottom_1;
    logic                  active, raw_hsync, raw_vsync, frame_start;
    logic                  within_0, within_1, rgb_en_0, rgb_en_1;
    game_sprite_pkg::rgb_t rgb_0, rgb_1;

    display_timing #(.screen_width(screen_width), .screen_height(screen_height),
                     .h_total(h_total), .v_total(v_total))
    timing_i (.clk(clk), .reset(reset), .pixel_x(pixel_x), .pixel_y(pixel_y),
              .active(active), .hsync(raw_hsync), .vsync(raw_vsync),
              .frame_start(frame_start));

    sprite_mover #(.screen_width(screen_width), .screen_height(screen_height),
                   .start_x(4), .start_y(4), .step_x(3), .step_y(2))
    mover_0_i (.clk(clk), .reset(reset), .frame_start(frame_start), .launch(launch),
               .collision(collision), .sprite_within_screen(within_0),
               .sprite_out_right(right_0), .sprite_out_bottom(bottom_0),
               .sprite_x(sprite_0_x), .sprite_y(sprite_0_y));

    sprite_mover #(.screen_width(screen_width), .screen_height(screen_height),
                   .start_x(48), .start_y(30), .step_x(2), .step_y(3))
    mover_1_i (.clk(clk), .reset(reset), .frame_start(frame_start), .launch(launch),
               .collision(collision), .sprite_within_screen(within_1),
               .sprite_out_right(right_1), .sprite_out_bottom(bottom_1),
               .sprite_x(sprite_1_x), .sprite_y(sprite_1_y));

    game_sprite_display #(.screen_width(screen_width), .screen_height(screen_height),
                          .sprite_width(sprite_width), .sprite_height(sprite_height),
                          .row_0(cross_bar), .row_1(cross_bar), .row_2(cross_bar),
                          .row_3(cross_line), .row_4(cross_line), .row_5(cross_bar),
                          .row_6(cross_bar), .row_7(cross_bar))
    sprite_0_i (.clk(clk), .reset(reset), .pixel_x(pixel_x), .pixel_y(pixel_y),
                .sprite_x(sprite_0_x), .sprite_y(sprite_0_y),
                .sprite_within_screen(within_0), .sprite_out_left(),
                .sprite_out_right(right_0), .sprite_out_top(),
                .sprite_out_bottom(bottom_0), .rgb_en(rgb_en_0), .rgb(rgb_0));

    game_sprite_display #(.screen_width(screen_width), .screen_height(screen_height),
                          .sprite_width(sprite_width), .sprite_height(sprite_height),
                          .row_0(square), .row_1(square), .row_2(square), .row_3(square),
                          .row_4(square), .row_5(square), .row_6(square), .row_7(square))
    sprite_1_i (.clk(clk), .reset(reset), .pixel_x(pixel_x), .pixel_y(pixel_y),
                .sprite_x(sprite_1_x), .sprite_y(sprite_1_y),
                .sprite_within_screen(within_1), .sprite_out_left(),
                .sprite_out_right(right_1), .sprite_out_top(),
                .sprite_out_bottom(bottom_1), .rgb_en(rgb_en_1), .rgb(rgb_1));

    pixel_mixer #(.background(background))
    mixer_i (.clk(clk), .reset(reset), .active(active), .hsync_in(raw_hsync),
             .vsync_in(raw_vsync), .rgb_en_0(rgb_en_0), .rgb_0(rgb_0),
             .rgb_en_1(rgb_en_1), .rgb_1(rgb_1), .video_on(video_on), .hsync(hsync),
             .vsync(vsync), .video_rgb(video_rgb), .collision(collision));

endmodule

// File: design/pixel_mixer.sv
`timescale 1ns/10ps

module pixel_mixer
#(
    parameter game_sprite_pkg::rgb_t background = 3'b001
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  active,
    input  logic                  hsync_in,
    input  logic                  vsync_in,
    input  logic                  rgb_en_0,
    input  game_sprite_pkg::rgb_t rgb_0,
    input  logic                  rgb_en_1,
    input  game_sprite_pkg::rgb_t rgb_1,
    output logic                  video_on,
    output logic                  hsync,
    output logic                  vsync,
    output game_sprite_pkg::rgb_t video_rgb,
    output logic                  collision
);

    logic active_d;                        // Aligned with the renderer outputs.
    logic hsync_d;
    logic vsync_d;

    game_sprite_pkg::rgb_t mix;

    // Sprite 0 over sprite 1 over the background.
    always_comb
        if (!active_d)
            mix = '0;                      // Black in blanking.
        else if (rgb_en_0)
            mix = rgb_0;
        else if (rgb_en_1)
            mix = rgb_1;
        else
            mix = background;

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            active_d  <= 1'b0;
            hsync_d   <= 1'b0;
            vsync_d   <= 1'b0;
            video_on  <= 1'b0;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            video_rgb <= '0;
            collision <= 1'b0;
        end
        else
        begin
            active_d  <= active;
            hsync_d   <= hsync_in;
            vsync_d   <= vsync_in;
            video_on  <= active_d;
            hsync     <= hsync_d;
            vsync     <= vsync_d;
            video_rgb <= mix;
            collision <= rgb_en_0 && rgb_en_1 && active_d;
        end

endmodule

// File: design/game_sprite_display.sv
`timescale 1ns/10ps

module game_sprite_display
#(
    parameter int screen_width  = 64,
    parameter int screen_height = 48,
    parameter int sprite_width  = 8,
    parameter int sprite_height = 8,

    parameter logic [31:0] row_0 = 32'h000cc000,
    parameter logic [31:0] row_1 = 32'h000cc000,
    parameter logic [31:0] row_2 = 32'h000cc000,
    parameter logic [31:0] row_3 = 32'hcccccccc,
    parameter logic [31:0] row_4 = 32'hcccccccc,
    parameter logic [31:0] row_5 = 32'h000cc000,
    parameter logic [31:0] row_6 = 32'h000cc000,
    parameter logic [31:0] row_7 = 32'h000cc000
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  game_screen_pkg::x_t   pixel_x,
    input  game_screen_pkg::y_t   pixel_y,
    input  game_screen_pkg::x_t   sprite_x,
    input  game_screen_pkg::y_t   sprite_y,
    output logic                  sprite_within_screen,
    output game_screen_pkg::x_t   sprite_out_left,
    output game_screen_pkg::x_t   sprite_out_right,
    output game_screen_pkg::y_t   sprite_out_top,
    output game_screen_pkg::y_t   sprite_out_bottom,
    output logic                  rgb_en,
    output game_sprite_pkg::rgb_t rgb
);

    localparam int xw         = game_screen_pkg::x_width;
    localparam int yw         = game_screen_pkg::y_width;
    localparam int ergb_width = game_sprite_pkg::ergb_width;

    localparam logic [xw:0] screen_w_1 = (xw + 1)'(screen_width - 1);
    localparam logic [yw:0] screen_h_1 = (yw + 1)'(screen_height - 1);
    localparam logic [xw:0] sprite_w_1 = (xw + 1)'(sprite_width - 1);
    localparam logic [yw:0] sprite_h_1 = (yw + 1)'(sprite_height - 1);

    // Sprite bounds; the top bit of each difference is the borrow.
    wire [xw:0] x_right     = {1'b0, sprite_x} + sprite_w_1;
    wire [xw:0] x_room      = screen_w_1 - x_right;
    wire        x_in_screen = !x_room[xw] && !x_right[xw];

    wire [yw:0] y_bottom    = {1'b0, sprite_y} + sprite_h_1;
    wire [yw:0] y_room      = screen_h_1 - y_bottom;
    wire        y_in_screen = !y_room[yw] && !y_bottom[yw];

    // Pixel against the sprite rectangle.
    wire [xw:0] x_offset    = {1'b0, pixel_x} - {1'b0, sprite_x};
    wire [xw:0] x_left_over = x_right - {1'b0, pixel_x};
    wire        x_hit       = !x_offset[xw] && !x_left_over[xw];

    wire [yw:0] y_offset    = {1'b0, pixel_y} - {1'b0, sprite_y};
    wire [yw:0] y_left_over = y_bottom - {1'b0, pixel_y};
    wire        y_hit       = !y_offset[yw] && !y_left_over[yw];

    wire [2:0] row_index    = y_offset[2:0];
    wire [2:0] column_index = x_offset[2:0];

    logic [sprite_width * ergb_width - 1:0] row;
    game_sprite_pkg::ergb_t                 ergb;

    always_comb
        case (row_index)
        3'd0: row = row_0;
        3'd1: row = row_1;
        3'd2: row = row_2;
        3'd3: row = row_3;
        3'd4: row = row_4;
        3'd5: row = row_5;
        3'd6: row = row_6;
        default: row = row_7;
        endcase

    // Leftmost column sits in the most significant nibble.
    assign ergb = row[(sprite_width - 1 - int'(column_index)) * ergb_width +: ergb_width];

    always_ff @(posedge clk or posedge reset)
        if (reset)
            rgb_en <= 1'b0;
        else
            rgb_en <= x_hit && y_hit && ergb[ergb_width - 1];

    always_ff @(posedge clk)
        rgb <= ergb[ergb_width - 2:0];

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            sprite_within_screen <= 1'b0;
            sprite_out_left      <= '0;
            sprite_out_right     <= '0;
            sprite_out_top       <= '0;
            sprite_out_bottom    <= '0;
        end
        else
        begin
            sprite_within_screen <= x_in_screen && y_in_screen;
            sprite_out_left      <= sprite_x;
            sprite_out_right     <= x_right[xw - 1:0];
            sprite_out_top       <= sprite_y;
            sprite_out_bottom    <= y_bottom[yw - 1:0];
        end

endmodule

// File: design/sprite_mover.sv
`timescale 1ns/10ps

module sprite_mover
#(
    parameter int screen_width  = 64,
    parameter int screen_height = 48,
    parameter int start_x       = 0,
    parameter int start_y       = 0,
    parameter int step_x        = 1,
    parameter int step_y        = 1
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_start,
    input  logic                launch,
    input  logic                collision,
    input  logic                sprite_within_screen,
    input  game_screen_pkg::x_t sprite_out_right,
    input  game_screen_pkg::y_t sprite_out_bottom,
    output game_screen_pkg::x_t sprite_x,
    output game_screen_pkg::y_t sprite_y
);

    localparam int xw = game_screen_pkg::x_width;
    localparam int yw = game_screen_pkg::y_width;

    localparam logic [xw:0] x_max = (xw + 1)'(screen_width - 1);
    localparam logic [yw:0] y_max = (yw + 1)'(screen_height - 1);
    localparam logic [xw:0] dx    = (xw + 1)'(step_x);
    localparam logic [yw:0] dy    = (yw + 1)'(step_y);

    game_sprite_pkg::mover_state_t state;

    logic x_back;                          // Moving toward x = 0.
    logic y_back;                          // Moving toward y = 0.

    wire [xw:0] x_far_next  = {1'b0, sprite_out_right} + dx;
    wire [xw:0] x_near_next = {1'b0, sprite_x} - dx;      // Borrow means below 0.
    wire [yw:0] y_far_next  = {1'b0, sprite_out_bottom} + dy;
    wire [yw:0] y_near_next = {1'b0, sprite_y} - dy;

    wire x_bounce = x_back ? x_near_next[xw] : x_far_next > x_max;
    wire y_bounce = y_back ? y_near_next[yw] : y_far_next > y_max;

    // Direction actually taken this frame.
    wire x_dir = x_back ^ x_bounce;
    wire y_dir = y_back ^ y_bounce;

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            state    <= game_sprite_pkg::mover_idle;
            x_back   <= 1'b0;
            y_back   <= 1'b0;
            sprite_x <= game_screen_pkg::x_t'(start_x);
            sprite_y <= game_screen_pkg::y_t'(start_y);
        end
        else
            case (state)
            game_sprite_pkg::mover_idle:
                if (launch && sprite_within_screen)
                    state <= game_sprite_pkg::mover_run;
            game_sprite_pkg::mover_run:
                if (collision)
                    state <= game_sprite_pkg::mover_frozen;
                else if (frame_start)
                begin
                    x_back   <= x_dir;
                    y_back   <= y_dir;
                    sprite_x <= x_dir ? x_near_next[xw - 1:0] : sprite_x + dx[xw - 1:0];
                    sprite_y <= y_dir ? y_near_next[yw - 1:0] : sprite_y + dy[yw - 1:0];
                end
            game_sprite_pkg::mover_frozen:
                state <= game_sprite_pkg::mover_frozen;  // Only reset leaves.
            default:
                state <= game_sprite_pkg::mover_idle;
            endcase

endmodule

// File: design/display_timing.sv
`timescale 1ns/10ps

module display_timing
#(
    parameter int screen_width  = 64,
    parameter int screen_height = 48,
    parameter int h_total       = 80,
    parameter int v_total       = 56
)
(
    input  logic                clk,
    input  logic                reset,
    output game_screen_pkg::x_t pixel_x,
    output game_screen_pkg::y_t pixel_y,
    output logic                active,
    output logic                hsync,
    output logic                vsync,
    output logic                frame_start
);

    localparam game_screen_pkg::x_t h_last      = game_screen_pkg::x_t'(h_total - 1);
    localparam game_screen_pkg::y_t v_last      = game_screen_pkg::y_t'(v_total - 1);
    localparam game_screen_pkg::x_t x_visible   = game_screen_pkg::x_t'(screen_width);
    localparam game_screen_pkg::y_t y_visible   = game_screen_pkg::y_t'(screen_height);
    localparam game_screen_pkg::x_t hsync_first = game_screen_pkg::x_t'(screen_width + 4);
    localparam game_screen_pkg::x_t hsync_last  = game_screen_pkg::x_t'(screen_width + 11);
    localparam game_screen_pkg::y_t vsync_first = game_screen_pkg::y_t'(screen_height + 2);
    localparam game_screen_pkg::y_t vsync_last  = game_screen_pkg::y_t'(screen_height + 3);

    game_screen_pkg::x_t next_x;
    game_screen_pkg::y_t next_y;

    always_comb
    begin
        next_x = pixel_x + 1'b1;
        next_y = pixel_y;
        if (pixel_x == h_last)
        begin
            next_x = '0;
            next_y = (pixel_y == v_last) ? '0 : pixel_y + 1'b1;
        end
    end

    // Decodes use the next position so they line up with the counters.
    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            pixel_x     <= h_last;         // First pixel after reset is (0, 0).
            pixel_y     <= v_last;
            active      <= 1'b0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            pixel_x     <= next_x;
            pixel_y     <= next_y;
            active      <= next_x < x_visible && next_y < y_visible;
            hsync       <= next_x >= hsync_first && next_x <= hsync_last;
            vsync       <= next_y >= vsync_first && next_y <= vsync_last;
            frame_start <= next_x == '0 && next_y == y_visible;  // First blanking line.
        end

endmodule

// File: design/game_sprite_pkg.sv
package game_sprite_pkg;

    localparam int rgb_width  = 3;
    localparam int ergb_width = 1 + rgb_width;

    // One bit each for red, green and blue.
    typedef logic [rgb_width - 1:0] rgb_t;

    // Bitmap nibble: enable on top, then red, green, blue.
    typedef logic [ergb_width - 1:0] ergb_t;

    // Sprite mover FSM.
    typedef enum logic [1:0]
    {
        mover_idle,                        // Parked at the start position.
        mover_run,                         // Stepping once per frame.
        mover_frozen                       // Stopped by a collision.
    } mover_state_t;

endpackage

// File: design/game_screen_pkg.sv
package game_screen_pkg;

    // Coordinate widths of the raster counters.
    localparam int x_width = 10;
    localparam int y_width = 10;

    // Horizontal pixel position, counted from the left edge.
    typedef logic [x_width - 1:0] x_t;

    // Vertical pixel position, counted from the top line.
    typedef logic [y_width - 1:0] y_t;

endpackage
